/* dv/llc_input_decoder_checker.sv */
// concurrent checks on the strobes and the output register of the llc input decoder
// attached to every llc_input_decoder instance by the bind below the module
module llc_input_decoder_checker
    import cache_pkg::*;
    import decoder_pkg::*;
(
    input logic       clk,
    input logic       rst,
    input logic       get_rst,
    input logic       get_rsp,
    input logic       get_req,
    input logic       get_dma,
    input logic       idle,
    input logic       out_valid,
    input logic       out_ready,
    input msg_kind_e  out_kind,
    input set_t       out_set,
    input tag_t       out_tag,
    input line_addr_t out_line_addr,
    input logic       out_dma_done
);

    // number of failed assertions so far
    int fail_count = 0;

    // one source consumed per cycle at most
    assert property (@(posedge clk) disable iff (!rst)
        $onehot0({get_rst, get_rsp, get_req, get_dma}))
        else begin
            fail_count++;
            $error("more than one get strobe high in one cycle");
        end

    // output register holds its item under back-pressure
    assert property (@(posedge clk) disable iff (!rst)
        out_valid && !out_ready |=> out_valid && $stable(out_kind)
            && $stable(out_line_addr) && $stable(out_set) && $stable(out_tag)
            && $stable(out_dma_done))
        else begin
            fail_count++;
            $error("output changed while out_ready was low");
        end

    assert property (@(posedge clk) disable iff (!rst)
        idle |-> !(get_rst || get_rsp || get_req || get_dma))
        else begin
            fail_count++;
            $error("get strobe high while the arbiter is idle");
        end

endmodule

bind llc_input_decoder llc_input_decoder_checker llc_input_decoder_checker_inst (
    .clk           (clk),
    .rst           (rst),
    .get_rst       (get_rst),
    .get_rsp       (get_rsp),
    .get_req       (get_req),
    .get_dma       (get_dma),
    .idle          (idle),
    .out_valid     (out_valid),
    .out_ready     (out_ready),
    .out_kind      (out_kind),
    .out_set       (out_set),
    .out_tag       (out_tag),
    .out_line_addr (out_line_addr),
    .out_dma_done  (out_dma_done)
);

/* dv/tb_llc_input_decoder.sv */
// testbench for the llc input decoder with seeded random sources and a cycle model
// strobes are compared every cycle, outputs in grant order against a scoreboard
module tb_llc_input_decoder;
    import cache_pkg::*;
    import decoder_pkg::*;

    localparam int SEED           = 32'h4197;
    localparam int NUM_TXN        = 300;
    localparam int CYCLES_PER_TXN = 40;
    localparam int CLK_PERIOD     = 10;

    logic         clk;
    logic         rst;
    logic         rst_tb_valid;
    logic         rsp_valid;
    line_addr_t   rsp_addr;
    logic         req_valid;
    line_addr_t   req_addr;
    logic         dma_valid;
    line_addr_t   dma_addr;
    word_offset_t dma_word_offset;
    dma_length_t  dma_length;
    logic         req_stall;
    logic         out_ready;
    logic         get_rst, get_rsp, get_req, get_dma;
    logic         idle;
    logic         out_valid;
    msg_kind_e    out_kind;
    set_t         out_set;
    tag_t         out_tag;
    line_addr_t   out_line_addr;
    logic         out_dma_done;

    // model of pipe register, output register and burst state
    logic         m_full;
    msg_kind_e    m_kind;
    line_addr_t   m_addr;
    word_offset_t m_off;
    dma_length_t  m_len;
    logic         m_out_valid;
    logic         m_burst_active;
    line_addr_t   m_burst_addr;
    int           m_covered;
    int           m_burst_len;
    logic         m_cont_if;
    logic         m_start_if;

    // expected outputs in grant order
    msg_kind_e    exp_kind_q[$];
    line_addr_t   exp_addr_q[$];
    logic         exp_done_q[$];
    int           burst_items_q[$];

    logic         taken_rst, taken_rsp, taken_req, taken_dma;
    int           grants;
    int           burst_count;
    int           strobe_errors;
    int           output_errors;

    llc_input_decoder llc_input_decoder_inst (
        .clk             (clk),
        .rst             (rst),
        .rst_tb_valid    (rst_tb_valid),
        .rsp_valid       (rsp_valid),
        .rsp_addr        (rsp_addr),
        .req_valid       (req_valid),
        .req_addr        (req_addr),
        .dma_valid       (dma_valid),
        .dma_addr        (dma_addr),
        .dma_word_offset (dma_word_offset),
        .dma_length      (dma_length),
        .req_stall       (req_stall),
        .out_ready       (out_ready),
        .get_rst         (get_rst),
        .get_rsp         (get_rsp),
        .get_req         (get_req),
        .get_dma         (get_dma),
        .idle            (idle),
        .out_valid       (out_valid),
        .out_kind        (out_kind),
        .out_set         (out_set),
        .out_tag         (out_tag),
        .out_line_addr   (out_line_addr),
        .out_dma_done    (out_dma_done)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic compare_val(input string name, input logic [31:0] exp,
                               input logic [31:0] act, input bit on_output);
        if (exp !== act) begin
            $display("[FAIL] t=%0t %s expected 'h%0h got 'h%0h", $time, name, exp, act);
            if (on_output) begin
                output_errors++;
            end else begin
                strobe_errors++;
            end
        end
    endtask

    // sources hold valid and data until their strobe was seen
    task automatic drive_inputs();
        bit open;
        open = grants < NUM_TXN;
        if (taken_rst || !rst_tb_valid) begin
            rst_tb_valid = open && ($urandom_range(31) == 0);
        end
        if (taken_rsp || !rsp_valid) begin
            rsp_valid = open && ($urandom_range(3) == 0);
            rsp_addr  = line_addr_t'($urandom);
        end
        if (taken_req || !req_valid) begin
            req_valid = open && ($urandom_range(2) == 0);
            req_addr  = line_addr_t'($urandom);
        end
        if (taken_dma || !dma_valid) begin
            dma_valid       = open && ($urandom_range(4) == 0);
            dma_addr        = line_addr_t'($urandom);
            dma_word_offset = word_offset_t'($urandom_range(3));
            dma_length      = dma_length_t'($urandom_range(24, 1));
        end
        // runs of stall and back-pressure, both released for the final drain
        if (!open) begin
            req_stall = 1'b0;
            out_ready = 1'b1;
        end else begin
            if ($urandom_range(5) == 0) req_stall = !req_stall;
            if ($urandom_range(3) == 0) out_ready = !out_ready;
        end
    endtask

    task automatic check_output();
        msg_kind_e  kind;
        line_addr_t addr;
        logic       done;
        if (exp_kind_q.size() == 0) begin
            $display("error: t=%0t output handshake with no item in flight", $time);
            output_errors++;
        end else begin
            kind = exp_kind_q.pop_front();
            addr = exp_addr_q.pop_front();
            done = exp_done_q.pop_front();
            compare_val("out_kind", kind, out_kind, 1'b1);
            compare_val("out_line_addr", addr, out_line_addr, 1'b1);
            compare_val("out_set", addr[SET_BITS-1:0], out_set, 1'b1);
            compare_val("out_tag", addr[LINE_ADDR_BITS-1:SET_BITS], out_tag, 1'b1);
            compare_val("out_dma_done", done, out_dma_done, 1'b1);
        end
        // line count of each burst, taken from the outputs alone
        if (out_kind == DMA_START) begin
            burst_count = 1;
        end else if (out_kind == DMA_CONT) begin
            burst_count++;
        end
        if (out_dma_done && burst_items_q.size() == 0) begin
            $display("error: t=%0t burst ended with no dma request granted", $time);
            output_errors++;
        end else if (out_dma_done) begin
            compare_val("dma burst items", burst_items_q.pop_front(), burst_count, 1'b1);
        end
    endtask

    // runs at the falling edge, then steps the model to the next rising edge
    task automatic eval_cycle();
        logic       dec_ready;
        logic       pipe_ready;
        logic       pick_valid;
        logic       load;
        logic       dec_take;
        logic       dma_item;
        logic       done;
        msg_kind_e  pick_kind;
        line_addr_t pick_addr;
        line_addr_t line;
        dec_ready  = !m_out_valid || out_ready;
        pipe_ready = !m_full || dec_ready;
        pick_valid = 1'b1;
        pick_kind  = RST;
        pick_addr  = '0;
        if (rst_tb_valid) begin
            pick_kind = RST;
        end else if (rsp_valid) begin
            pick_kind = RSP;
            pick_addr = rsp_addr;
        end else if (req_valid && !req_stall) begin
            pick_kind = REQ;
            pick_addr = req_addr;
        end else if (m_burst_active && !m_cont_if) begin
            pick_kind = DMA_CONT;
        end else if (dma_valid && !req_stall && !m_burst_active && !m_start_if) begin
            pick_kind = DMA_START;
            pick_addr = dma_addr;
        end else begin
            pick_valid = 1'b0;
        end
        load = pick_valid && pipe_ready;
        compare_val("idle", !pick_valid, idle, 1'b0);
        compare_val("get_rst", load && pick_kind == RST, get_rst, 1'b0);
        compare_val("get_rsp", load && pick_kind == RSP, get_rsp, 1'b0);
        compare_val("get_req", load && pick_kind == REQ, get_req, 1'b0);
        compare_val("get_dma", load && pick_kind == DMA_START, get_dma, 1'b0);
        compare_val("out_valid", m_out_valid, out_valid, 1'b0);
        taken_rst = get_rst;
        taken_rsp = get_rsp;
        taken_req = get_req;
        taken_dma = get_dma;
        grants = grants + int'(get_rst) + int'(get_rsp) + int'(get_req) + int'(get_dma);
        // smallest n with 4n - offset reaching the length
        if (get_dma) begin
            burst_items_q.push_back((int'(dma_length) + int'(dma_word_offset) + 3) / 4);
        end
        if (out_valid && out_ready) begin
            check_output();
        end
        dec_take = m_full && dec_ready;
        dma_item = dec_take && (m_kind == DMA_START || m_kind == DMA_CONT);
        done     = 1'b0;
        line     = m_addr;
        if (dec_take) begin
            case (m_kind)
                RST: begin
                    line = '0;
                end
                DMA_START: begin
                    m_covered    = WORDS_PER_LINE - int'(m_off);
                    m_burst_len  = int'(m_len);
                    done         = m_covered >= m_burst_len;
                    m_burst_addr = line;
                end
                DMA_CONT: begin
                    line         = m_burst_addr + 1'b1;
                    m_covered    = m_covered + WORDS_PER_LINE;
                    done         = m_covered >= m_burst_len;
                    m_burst_addr = line;
                end
                default: begin
                    line = m_addr;
                end
            endcase
            exp_kind_q.push_back(m_kind);
            exp_addr_q.push_back(line);
            exp_done_q.push_back(done);
        end
        if (load && pick_kind == DMA_CONT) begin
            m_cont_if = 1'b1;
        end else if (dma_item) begin
            m_cont_if = 1'b0;
        end
        if (load && pick_kind == DMA_START) begin
            m_start_if = 1'b1;
        end else if (dma_item || m_burst_active) begin
            m_start_if = 1'b0;
        end
        if (dma_item) m_burst_active = !done;
        if (dec_ready) m_out_valid = m_full;
        if (load) begin
            m_full = 1'b1;
            m_kind = pick_kind;
            m_addr = pick_addr;
            m_off  = dma_word_offset;
            m_len  = dma_length;
        end else if (dec_ready) begin
            m_full = 1'b0;
        end
    endtask

    initial begin
        void'($urandom(SEED));
        rst             = 1'b0;
        rst_tb_valid    = 1'b0;
        rsp_valid       = 1'b0;
        rsp_addr        = '0;
        req_valid       = 1'b0;
        req_addr        = '0;
        dma_valid       = 1'b0;
        dma_addr        = '0;
        dma_word_offset = '0;
        dma_length      = '0;
        req_stall       = 1'b0;
        out_ready       = 1'b0;
        {m_full, m_out_valid, m_burst_active, m_cont_if, m_start_if} = '0;
        {taken_rst, taken_rsp, taken_req, taken_dma} = '0;
        m_kind          = RST;
        m_addr          = '0;
        m_off           = '0;
        m_len           = '0;
        m_burst_addr    = '0;
        m_covered       = 0;
        m_burst_len     = 0;
        grants          = 0;
        burst_count     = 0;
        strobe_errors   = 0;
        output_errors   = 0;
        // reset spans eight rising edges, released just after the last one
        repeat (7) begin
            @(posedge clk);
            #5;
            compare_val("get_rst", 1'b0, get_rst, 1'b0);
            compare_val("get_rsp", 1'b0, get_rsp, 1'b0);
            compare_val("get_req", 1'b0, get_req, 1'b0);
            compare_val("get_dma", 1'b0, get_dma, 1'b0);
            compare_val("out_valid", 1'b0, out_valid, 1'b0);
        end
        @(posedge clk);
        #1;
        rst = 1'b1;
        #4;
        eval_cycle();
        while (grants < NUM_TXN || rst_tb_valid || rsp_valid || req_valid || dma_valid
               || m_full || m_out_valid || m_burst_active) begin
            @(posedge clk);
            #1;
            drive_inputs();
            #4;
            eval_cycle();
        end
        if (exp_kind_q.size() != 0 || burst_items_q.size() != 0) begin
            $display("error: %0d outputs and %0d bursts still expected at the end",
                     exp_kind_q.size(), burst_items_q.size());
            output_errors++;
        end
        $display("strobe errors: %0d, output errors: %0d, assertion errors: %0d",
                 strobe_errors, output_errors,
                 llc_input_decoder_inst.llc_input_decoder_checker_inst.fail_count);
        if (strobe_errors == 0 && output_errors == 0
            && llc_input_decoder_inst.llc_input_decoder_checker_inst.fail_count == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

    initial begin
        #(NUM_TXN * CYCLES_PER_TXN * CLK_PERIOD);
        $display("timeout: run did not end within %0d cycles", NUM_TXN * CYCLES_PER_TXN);
        $display("strobe errors: %0d, output errors: %0d, assertion errors: %0d",
                 strobe_errors, output_errors,
                 llc_input_decoder_inst.llc_input_decoder_checker_inst.fail_count);
        $display("Some tests failed");
        $finish;
    end

endmodule

/* project.f */
src/cache_pkg.sv
src/decoder_pkg.sv
src/decode_stage_if.sv
src/input_arbiter.sv
src/decode_pipe_reg.sv
src/line_decoder.sv
src/llc_input_decoder.sv
dv/llc_input_decoder_checker.sv
dv/tb_llc_input_decoder.sv

/* src/cache_pkg.sv */
// last-level cache address geometry and field types
// imported by every RTL block that handles line addresses or DMA lengths
package cache_pkg;

    // byte address and line layout
    localparam int ADDR_BITS        = 32;
    localparam int OFFSET_BITS      = 4;
    localparam int WORD_OFFSET_BITS = 2;
    localparam int WORDS_PER_LINE   = 4;
    localparam int LINE_ADDR_BITS   = ADDR_BITS - OFFSET_BITS;

    // set index sits in the low line address bits, tag above it
    localparam int SET_BITS = 8;
    localparam int TAG_BITS = LINE_ADDR_BITS - SET_BITS;

    // dma burst length in words
    localparam int DMA_LEN_BITS = 16;
    // one spare bit so the covered count cannot wrap past the length
    localparam int DMA_COUNT_BITS = DMA_LEN_BITS + 1;

    typedef logic [LINE_ADDR_BITS-1:0]   line_addr_t;
    typedef logic [SET_BITS-1:0]         set_t;
    typedef logic [TAG_BITS-1:0]         tag_t;
    typedef logic [WORD_OFFSET_BITS-1:0] word_offset_t;
    typedef logic [DMA_LEN_BITS-1:0]     dma_length_t;
    typedef logic [DMA_COUNT_BITS-1:0]   dma_count_t;

endpackage

/* src/decode_pipe_reg.sv */
// one-entry valid/ready register between the arbiter and the line decoder
// accepts a new item in the same cycle the held one drains
module decode_pipe_reg
    import decoder_pkg::*;
(
    input  logic clk,
    input  logic rst,
    decode_stage_if.receiver up,
    decode_stage_if.sender   down
);

    logic      full;
    decision_t data;
    logic      load;

    assign up.ready      = !full || down.ready;
    assign load          = up.valid && up.ready;
    assign down.valid    = full;
    assign down.decision = data;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            full <= 1'b0;
        end else if (load) begin
            full <= 1'b1;
        end else if (down.ready) begin
            full <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            data <= up.decision;
        end
    end

endmodule

/* src/decode_stage_if.sv */
// valid/ready link carrying one decision between two pipeline stages
// a transfer happens on a rising edge with valid and ready both high
interface decode_stage_if
    import decoder_pkg::*;
(
    input logic clk
);

    logic      valid;
    logic      ready;
    // held stable by the sender while valid is high and ready is low
    decision_t decision;

    modport sender (
        input  clk,
        input  ready,
        output valid,
        output decision
    );

    modport receiver (
        input  clk,
        input  valid,
        input  decision,
        output ready
    );

endinterface

/* src/decoder_pkg.sv */
// message kinds and the decision record passed from arbiter to line decoder
// shared by the arbiter, the pipe register, the decoder and the stage interface
package decoder_pkg;

    import cache_pkg::*;

    localparam int KIND_BITS = 3;

    // kind of message chosen by the arbiter
    typedef enum logic [KIND_BITS-1:0] {
        RST       = 3'd0,
        RSP       = 3'd1,
        REQ       = 3'd2,
        DMA_START = 3'd3,
        DMA_CONT  = 3'd4
    } msg_kind_e;

    // one selected message on its way to the decode stage
    // continuations and reset items leave the address fields at zero
    typedef struct packed {
        msg_kind_e    kind;
        line_addr_t   line_addr;
        word_offset_t word_offset;
        dma_length_t  dma_length;
    } decision_t;

endpackage

/* src/input_arbiter.sv */
// fixed-priority pick of the next incoming message for the decode pipeline
// drives the consume strobes back to the sources in the cycle of acceptance
module input_arbiter
    import cache_pkg::*;
    import decoder_pkg::*;
(
    input  logic         clk,
    input  logic         rst,
    input  logic         rst_tb_valid,
    input  logic         rsp_valid,
    input  line_addr_t   rsp_addr,
    input  logic         req_valid,
    input  line_addr_t   req_addr,
    input  logic         dma_valid,
    input  line_addr_t   dma_addr,
    input  word_offset_t dma_word_offset,
    input  dma_length_t  dma_length,
    input  logic         req_stall,
    input  logic         burst_active,
    input  logic         cont_done,
    output logic         get_rst,
    output logic         get_rsp,
    output logic         get_req,
    output logic         get_dma,
    output logic         idle,
    decode_stage_if.sender to_pipe
);

    logic      can_rst;
    logic      can_rsp;
    logic      can_req;
    logic      can_cont;
    logic      can_dma;
    logic      pick_valid;
    decision_t pick;
    logic      accept;
    logic      cont_in_flight;
    logic      start_in_flight;

    // eligibility per source
    assign can_rst  = rst_tb_valid;
    assign can_rsp  = rsp_valid;
    assign can_req  = req_valid && !req_stall;
    // only one continuation may sit in the pipeline at a time
    assign can_cont = burst_active && !cont_in_flight;
    // new burst waits until the previous one is fully decoded
    assign can_dma  = dma_valid && !req_stall && !burst_active && !start_in_flight;

    always_comb begin
        pick       = '0;
        pick_valid = 1'b1;
        if (can_rst) begin
            pick.kind = RST;
        end else if (can_rsp) begin
            pick.kind      = RSP;
            pick.line_addr = rsp_addr;
        end else if (can_req) begin
            pick.kind      = REQ;
            pick.line_addr = req_addr;
        end else if (can_cont) begin
            // address comes from the decoder's burst state
            pick.kind = DMA_CONT;
        end else if (can_dma) begin
            pick.kind        = DMA_START;
            pick.line_addr   = dma_addr;
            pick.word_offset = dma_word_offset;
            pick.dma_length  = dma_length;
        end else begin
            pick_valid = 1'b0;
        end
    end

    assign idle             = !pick_valid;
    assign to_pipe.valid    = pick_valid;
    assign to_pipe.decision = pick;
    assign accept           = to_pipe.valid && to_pipe.ready;

    // strobes only when the pipe register takes the item
    assign get_rst = accept && (pick.kind == RST);
    assign get_rsp = accept && (pick.kind == RSP);
    assign get_req = accept && (pick.kind == REQ);
    assign get_dma = accept && (pick.kind == DMA_START);

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            cont_in_flight <= 1'b0;
        end else if (accept && pick.kind == DMA_CONT) begin
            cont_in_flight <= 1'b1;
        end else if (cont_done) begin
            cont_in_flight <= 1'b0;
        end
    end

    // guards the gap between start grant and burst state in the decoder
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            start_in_flight <= 1'b0;
        end else if (accept && pick.kind == DMA_START) begin
            start_in_flight <= 1'b1;
        end else if (cont_done || burst_active) begin
            start_in_flight <= 1'b0;
        end
    end

endmodule

/* src/line_decoder.sv */
// decode stage: splits the line address into set and tag and tracks dma bursts
// results leave through a registered output with back-pressure on out_ready
module line_decoder
    import cache_pkg::*;
    import decoder_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    decode_stage_if.receiver from_pipe,
    input  logic       out_ready,
    output logic       burst_active,
    output logic       cont_done,
    output logic       out_valid,
    output msg_kind_e  out_kind,
    output set_t       out_set,
    output tag_t       out_tag,
    output line_addr_t out_line_addr,
    output logic       out_dma_done
);

    decision_t   d;
    logic        accept;
    logic        dma_take;
    line_addr_t  burst_addr;
    dma_count_t  covered;
    dma_length_t burst_len;
    line_addr_t  line_next;
    dma_count_t  covered_next;
    logic        done_next;

    assign d = from_pipe.decision;

    // output register empty or draining this cycle
    assign from_pipe.ready = !out_valid || out_ready;
    assign accept          = from_pipe.valid && from_pipe.ready;
    assign dma_take        = accept && (d.kind == DMA_START || d.kind == DMA_CONT);

    // a start also counts, so the arbiter can drop its start guard
    assign cont_done = dma_take;

    always_comb begin
        line_next    = d.line_addr;
        covered_next = covered;
        done_next    = 1'b0;
        case (d.kind)
            RST: begin
                line_next = '0;
            end
            DMA_START: begin
                // first line only covers words from the start offset onward
                covered_next = dma_count_t'(WORDS_PER_LINE) - dma_count_t'(d.word_offset);
                done_next    = covered_next >= dma_count_t'(d.dma_length);
            end
            DMA_CONT: begin
                line_next    = burst_addr + line_addr_t'(1);
                covered_next = covered + dma_count_t'(WORDS_PER_LINE);
                done_next    = covered_next >= dma_count_t'(burst_len);
            end
            default: begin
                line_next = d.line_addr;
            end
        endcase
    end

    // burst bookkeeping
    always_ff @(posedge clk) begin
        if (accept && d.kind == DMA_START) begin
            burst_len <= d.dma_length;
        end
        if (dma_take) begin
            burst_addr <= line_next;
            covered    <= covered_next;
        end
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            burst_active <= 1'b0;
        end else if (dma_take) begin
            // stays up until the last line of the burst is decoded
            burst_active <= !done_next;
        end
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            out_valid    <= 1'b0;
            out_dma_done <= 1'b0;
        end else if (from_pipe.ready) begin
            out_valid    <= from_pipe.valid;
            out_dma_done <= from_pipe.valid && done_next;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            out_kind      <= d.kind;
            out_line_addr <= line_next;
            out_set       <= line_next[SET_BITS-1:0];
            out_tag       <= line_next[LINE_ADDR_BITS-1:SET_BITS];
        end
    end

endmodule

/* src/llc_input_decoder.sv */
// input stage of the llc controller: arbiter, pipe register and line decoder
// sources hold valid and data until their get strobe is seen high
module llc_input_decoder
    import cache_pkg::*;
    import decoder_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  rst_tb_valid,
    input  logic                  rsp_valid,
    input  line_addr_t            rsp_addr,
    input  logic                  req_valid,
    input  line_addr_t            req_addr,
    input  logic                  dma_valid,
    input  line_addr_t            dma_addr,
    input  word_offset_t          dma_word_offset,
    input  dma_length_t           dma_length,
    input  logic                  req_stall,
    input  logic                  out_ready,
    output logic                  get_rst,
    output logic                  get_rsp,
    output logic                  get_req,
    output logic                  get_dma,
    output logic                  idle,
    output logic                  out_valid,
    output msg_kind_e             out_kind,
    output set_t                  out_set,
    output tag_t                  out_tag,
    output line_addr_t            out_line_addr,
    output logic                  out_dma_done
);

    logic burst_active;
    logic cont_done;

    decode_stage_if arb_to_pipe (.clk(clk));
    decode_stage_if pipe_to_dec (.clk(clk));

    input_arbiter input_arbiter_inst (
        .clk             (clk),
        .rst             (rst),
        .rst_tb_valid    (rst_tb_valid),
        .rsp_valid       (rsp_valid),
        .rsp_addr        (rsp_addr),
        .req_valid       (req_valid),
        .req_addr        (req_addr),
        .dma_valid       (dma_valid),
        .dma_addr        (dma_addr),
        .dma_word_offset (dma_word_offset),
        .dma_length      (dma_length),
        .req_stall       (req_stall),
        .burst_active    (burst_active),
        .cont_done       (cont_done),
        .get_rst         (get_rst),
        .get_rsp         (get_rsp),
        .get_req         (get_req),
        .get_dma         (get_dma),
        .idle            (idle),
        .to_pipe         (arb_to_pipe.sender)
    );

    decode_pipe_reg decode_pipe_reg_inst (
        .clk  (clk),
        .rst  (rst),
        .up   (arb_to_pipe.receiver),
        .down (pipe_to_dec.sender)
    );

    line_decoder line_decoder_inst (
        .clk           (clk),
        .rst           (rst),
        .from_pipe     (pipe_to_dec.receiver),
        .out_ready     (out_ready),
        .burst_active  (burst_active),
        .cont_done     (cont_done),
        .out_valid     (out_valid),
        .out_kind      (out_kind),
        .out_set       (out_set),
        .out_tag       (out_tag),
        .out_line_addr (out_line_addr),
        .out_dma_done  (out_dma_done)
    );

endmodule
